/* Bender.yml */
package:
  name: issue_stage

sources:
  - rtl/issue_pkg.sv
  - rtl/inst_decode.sv
  - rtl/operand_forward.sv
  - rtl/issue_ctrl.sv
  - rtl/issue_stage.sv
  - target: simulation
    files:
      - tb/tb_issue_stage.sv

/* all.f */
rtl/issue_pkg.sv
rtl/inst_decode.sv
rtl/operand_forward.sv
rtl/issue_ctrl.sv
rtl/issue_stage.sv
tb/tb_issue_stage.sv

/* rtl/inst_decode.sv */
// Combinational RV32I decode for the issue stage: register indices, immediates
// and the unit and operation the instruction is routed to.
`timescale 1ns/1ps
`default_nettype none

module inst_decode (
    input  issue_pkg::word_t    i_inst,
    output issue_pkg::reg_idx_t o_rs1,
    output issue_pkg::reg_idx_t o_rs2,
    output issue_pkg::decode_t  o_dec
);
    import issue_pkg::*;

    opcode_t  opcode;
    logic [2:0] funct3;
    logic     funct7_5;
    reg_idx_t rd;
    word_t    i_imm;
    word_t    b_imm;
    word_t    u_imm;

    assign opcode   = opcode_t'(i_inst[6:0]);
    assign funct3   = i_inst[14:12];
    assign funct7_5 = i_inst[30];
    assign rd       = i_inst[11:7];
    assign o_rs1    = i_inst[19:15];
    assign o_rs2    = i_inst[24:20];

    assign i_imm = {{20{i_inst[31]}}, i_inst[31:20]};
    assign b_imm = {{20{i_inst[31]}}, i_inst[7], i_inst[30:25], i_inst[11:8], 1'b0};
    assign u_imm = {i_inst[31:12], 12'h000};

    always_comb begin
        o_dec.unit      = UNIT_NONE;
        o_dec.alu_op    = alu_add;
        o_dec.cmp_op    = cmp_beq;
        o_dec.is_br     = 1'b0;
        o_dec.src_a     = SRC_A_RS1;
        o_dec.use_imm_b = 1'b0;
        o_dec.writes_rd = 1'b0;
        o_dec.rd        = rd;
        o_dec.imm       = i_imm;
        o_dec.b_imm     = b_imm;

        case (opcode)
            op_imm, op_reg: begin
                o_dec.writes_rd = 1'b1;
                o_dec.use_imm_b = (opcode == op_imm);
                case (funct3)
                    3'b010: begin  // SLT(I) as a compare
                        o_dec.unit   = UNIT_CMP;
                        o_dec.cmp_op = cmp_blt;
                    end
                    3'b011: begin
                        o_dec.unit   = UNIT_CMP;
                        o_dec.cmp_op = cmp_bltu;
                    end
                    3'b000: begin
                        o_dec.unit   = UNIT_ALU;
                        // ADDI has no funct7, its bit 30 is immediate
                        o_dec.alu_op = (opcode == op_reg && funct7_5) ? alu_sub : alu_add;
                    end
                    3'b101: begin
                        o_dec.unit   = UNIT_ALU;
                        o_dec.alu_op = funct7_5 ? alu_sra : alu_srl;
                    end
                    default: begin
                        o_dec.unit   = UNIT_ALU;
                        o_dec.alu_op = alu_op_t'(funct3);  // sll, xor, or, and line up
                    end
                endcase
            end

            op_lui: begin
                o_dec.unit      = UNIT_ALU;
                o_dec.writes_rd = 1'b1;
                o_dec.src_a     = SRC_A_ZERO;
                o_dec.use_imm_b = 1'b1;
                o_dec.imm       = u_imm;
            end

            op_auipc: begin
                o_dec.unit      = UNIT_ALU;
                o_dec.writes_rd = 1'b1;
                o_dec.src_a     = SRC_A_PC;  // PC + U immediate
                o_dec.use_imm_b = 1'b1;
                o_dec.imm       = u_imm;
            end

            op_br: begin
                // funct3 010 and 011 are not branches
                if (funct3[2:1] != 2'b01) begin
                    o_dec.unit   = UNIT_CMP;
                    o_dec.cmp_op = cmp_op_t'(funct3);
                    o_dec.is_br  = 1'b1;
                end
            end

            // Loads, stores and jumps are not issued by this stage
            default: o_dec.unit = UNIT_NONE;
        endcase

        if (o_dec.writes_rd && rd == '0) begin
            o_dec.unit = UNIT_NONE;  // Result to x0 is dropped
        end
    end

endmodule

`default_nettype wire

/* rtl/issue_ctrl.sv */
// Issue decision for one decoded instruction: queue shift, rename strobes, and
// the registered reservation-station and ROB entries one cycle later.
`timescale 1ns/1ps
`default_nettype none

module issue_ctrl (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     i_valid,
    input  issue_pkg::fetch_pkt_t    i_fetch,
    input  issue_pkg::decode_t       i_dec,
    input  issue_pkg::operand_t      i_op_j,
    input  issue_pkg::operand_t      i_op_k,
    input  issue_pkg::tag_t          i_free_tag,
    input  logic                     i_alu_ready,
    input  logic                     i_cmp_ready,
    output logic                     o_shift,
    output logic                     o_load_tag,
    output issue_pkg::tag_t          o_tag,
    output issue_pkg::reg_idx_t      o_rd,
    output logic                     o_rob_valid,
    output issue_pkg::rob_entry_t    o_rob,
    output logic                     o_alu_valid,
    output issue_pkg::alu_rs_entry_t o_alu,
    output logic                     o_cmp_valid,
    output issue_pkg::cmp_rs_entry_t o_cmp
);
    import issue_pkg::*;

    logic          unit_ready;
    logic          issue;
    operand_t      op_a;
    operand_t      op_b;
    alu_rs_entry_t alu_next;
    cmp_rs_entry_t cmp_next;
    rob_entry_t    rob_next;

    always_comb begin
        case (i_dec.unit)
            UNIT_ALU: unit_ready = i_alu_ready;
            UNIT_CMP: unit_ready = i_cmp_ready;
            default:  unit_ready = 1'b0;
        endcase
    end

    assign issue = i_valid && (i_dec.unit != UNIT_NONE) && (i_free_tag != '0) && unit_ready;

    // Queue pop and register rename happen in the decision cycle
    assign o_shift    = issue;
    assign o_load_tag = issue && i_dec.writes_rd;
    assign o_tag      = o_load_tag ? i_free_tag : '0;
    assign o_rd       = o_load_tag ? i_dec.rd : '0;

    always_comb begin
        case (i_dec.src_a)
            SRC_A_PC:   op_a = '{v: i_fetch.pc, q: '0};
            SRC_A_ZERO: op_a = '0;
            default:    op_a = i_op_j;
        endcase
        op_b = i_dec.use_imm_b ? '{v: i_dec.imm, q: '0} : i_op_k;
    end

    always_comb begin
        alu_next.vj     = op_a.v;
        alu_next.vk     = op_b.v;
        alu_next.qj     = op_a.q;
        alu_next.qk     = op_b.q;
        alu_next.alu_op = i_dec.alu_op;
        alu_next.dest   = i_free_tag;

        cmp_next.is_br   = i_dec.is_br;
        cmp_next.vj      = op_a.v;
        cmp_next.vk      = op_b.v;
        cmp_next.qj      = op_a.q;
        cmp_next.qk      = op_b.q;
        cmp_next.cmp_op  = i_dec.cmp_op;
        cmp_next.dest    = i_free_tag;
        cmp_next.pc      = i_fetch.pc;  // Only meaningful for branches
        cmp_next.b_imm   = i_dec.b_imm;
        cmp_next.br_pred = i_fetch.br_pred;

        rob_next.op   = i_dec.is_br ? BR : REG;
        rob_next.dest = i_dec.is_br ? '0 : i_dec.rd;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            o_alu_valid <= 1'b0;
            o_cmp_valid <= 1'b0;
            o_rob_valid <= 1'b0;
        end else begin
            o_alu_valid <= issue && (i_dec.unit == UNIT_ALU);
            o_cmp_valid <= issue && (i_dec.unit == UNIT_CMP);
            o_rob_valid <= issue;
        end
    end

    always_ff @(posedge clk) begin
        if (issue) begin
            o_rob <= rob_next;
        end
        if (issue && i_dec.unit == UNIT_ALU) begin
            o_alu <= alu_next;
        end
        if (issue && i_dec.unit == UNIT_CMP) begin
            o_cmp <= cmp_next;
        end
    end

    // Only one station takes an instruction per cycle
    assert property (@(posedge clk) disable iff (rst)
        !(o_alu_valid && o_cmp_valid))
        else $error("both station pulses high in one cycle");

    // A renamed register must get a REG entry in the ROB next cycle
    assert property (@(posedge clk) disable iff (rst)
        o_load_tag |-> o_shift ##1 (o_rob_valid && o_rob.op == REG))
        else $error("rename without a matching REG ROB entry");

endmodule

`default_nettype wire

/* rtl/issue_pkg.sv */
// Shared widths, types and entry formats for the Tomasulo issue stage.
// Modules import this package in their bodies and use scoped names in their ports.
`default_nettype none

package issue_pkg;

    localparam int XLEN      = 32;
    localparam int REG_IDX_W = 5;
    localparam int ROB_DEPTH = 8;
    localparam int TAG_W     = 3;  // Tag 0 means the value is present

    typedef logic [XLEN-1:0]      word_t;
    typedef logic [REG_IDX_W-1:0] reg_idx_t;
    typedef logic [TAG_W-1:0]     tag_t;

    // Dropped opcodes are listed so decode can recognise and refuse them
    typedef enum logic [6:0] {
        op_lui   = 7'b0110111,
        op_auipc = 7'b0010111,
        op_jal   = 7'b1101111,
        op_jalr  = 7'b1100111,
        op_br    = 7'b1100011,
        op_load  = 7'b0000011,
        op_store = 7'b0100011,
        op_imm   = 7'b0010011,
        op_reg   = 7'b0110011
    } opcode_t;

    // Slots 2 and 3 (slt, sltu in funct3) carry sra and sub instead
    typedef enum logic [2:0] {
        alu_add = 3'b000,
        alu_sll = 3'b001,
        alu_sra = 3'b010,
        alu_sub = 3'b011,
        alu_xor = 3'b100,
        alu_srl = 3'b101,
        alu_or  = 3'b110,
        alu_and = 3'b111
    } alu_op_t;

    typedef enum logic [2:0] {
        cmp_beq  = 3'b000,
        cmp_bne  = 3'b001,
        cmp_blt  = 3'b100,
        cmp_bge  = 3'b101,
        cmp_bltu = 3'b110,
        cmp_bgeu = 3'b111
    } cmp_op_t;

    typedef enum logic {REG, BR} rob_op_t;

    typedef enum logic [1:0] {UNIT_NONE, UNIT_ALU, UNIT_CMP} unit_t;

    typedef enum logic [1:0] {SRC_A_RS1, SRC_A_PC, SRC_A_ZERO} src_a_t;

    // Head of the instruction queue
    typedef struct packed {
        word_t pc;
        word_t inst;
        logic  br_pred;
    } fetch_pkt_t;

    typedef struct packed {
        tag_t  qj;
        tag_t  qk;
        word_t vj;
        word_t vk;
    } reg_src_t;

    typedef struct packed {
        logic [ROB_DEPTH-1:0]  ready;
        word_t [ROB_DEPTH-1:0] vals;
        tag_t                  free_tag;  // 0 when the ROB is full
    } rob_status_t;

    typedef struct packed {
        word_t v;
        tag_t  q;
    } operand_t;

    typedef struct packed {
        unit_t    unit;
        alu_op_t  alu_op;
        cmp_op_t  cmp_op;
        logic     is_br;
        src_a_t   src_a;
        logic     use_imm_b;
        logic     writes_rd;
        reg_idx_t rd;
        word_t    imm;
        word_t    b_imm;
    } decode_t;

    typedef struct packed {
        word_t   vj;
        word_t   vk;
        tag_t    qj;
        tag_t    qk;
        alu_op_t alu_op;
        tag_t    dest;
    } alu_rs_entry_t;

    typedef struct packed {
        logic    is_br;
        word_t   vj;
        word_t   vk;
        tag_t    qj;
        tag_t    qk;
        cmp_op_t cmp_op;
        tag_t    dest;
        word_t   pc;
        word_t   b_imm;
        logic    br_pred;
    } cmp_rs_entry_t;

    typedef struct packed {
        rob_op_t  op;
        reg_idx_t dest;
    } rob_entry_t;

endpackage

`default_nettype wire

/* rtl/issue_stage.sv */
// Issue stage top: decodes the instruction queue head, resolves operands and
// issues to the ALU or compare reservation station with a new ROB entry.
`timescale 1ns/1ps
`default_nettype none

module issue_stage (
    input  logic                     clk,
    input  logic                     rst,
    // Instruction queue
    input  logic                     i_valid,
    input  issue_pkg::fetch_pkt_t    i_fetch,
    output logic                     o_shift,
    // Register file
    output issue_pkg::reg_idx_t      o_rs1,
    output issue_pkg::reg_idx_t      o_rs2,
    input  issue_pkg::reg_src_t      i_reg_src,
    output logic                     o_load_tag,
    output issue_pkg::tag_t          o_tag,
    output issue_pkg::reg_idx_t      o_rd,
    // ROB
    input  issue_pkg::rob_status_t   i_rob,
    output logic                     o_rob_valid,
    output issue_pkg::rob_entry_t    o_rob,
    // Reservation stations
    input  logic                     i_alu_ready,
    output logic                     o_alu_valid,
    output issue_pkg::alu_rs_entry_t o_alu,
    input  logic                     i_cmp_ready,
    output logic                     o_cmp_valid,
    output issue_pkg::cmp_rs_entry_t o_cmp
);
    import issue_pkg::*;

    decode_t  dec;
    operand_t op_j;
    operand_t op_k;

    inst_decode inst_decode_i (
        .i_inst (i_fetch.inst),
        .o_rs1  (o_rs1),
        .o_rs2  (o_rs2),
        .o_dec  (dec)
    );

    operand_forward operand_forward_i (
        .i_reg_src (i_reg_src),
        .i_rob     (i_rob),
        .o_op_j    (op_j),
        .o_op_k    (op_k)
    );

    issue_ctrl issue_ctrl_i (
        .clk         (clk),
        .rst         (rst),
        .i_valid     (i_valid),
        .i_fetch     (i_fetch),
        .i_dec       (dec),
        .i_op_j      (op_j),
        .i_op_k      (op_k),
        .i_free_tag  (i_rob.free_tag),
        .i_alu_ready (i_alu_ready),
        .i_cmp_ready (i_cmp_ready),
        .o_shift     (o_shift),
        .o_load_tag  (o_load_tag),
        .o_tag       (o_tag),
        .o_rd        (o_rd),
        .o_rob_valid (o_rob_valid),
        .o_rob       (o_rob),
        .o_alu_valid (o_alu_valid),
        .o_alu       (o_alu),
        .o_cmp_valid (o_cmp_valid),
        .o_cmp       (o_cmp)
    );

endmodule

`default_nettype wire

/* rtl/operand_forward.sv */
// Resolves the register-file source operands against ready ROB results.
// Purely combinational, sits between the register file read and issue control.
`timescale 1ns/1ps
`default_nettype none

module operand_forward (
    input  issue_pkg::reg_src_t    i_reg_src,
    input  issue_pkg::rob_status_t i_rob,
    output issue_pkg::operand_t    o_op_j,
    output issue_pkg::operand_t    o_op_k
);
    import issue_pkg::*;

    function automatic operand_t resolve(input tag_t q, input word_t v, input rob_status_t rob);
        operand_t res;
        if (q != '0 && rob.ready[q]) begin
            res.v = rob.vals[q];  // Result already in the ROB
            res.q = '0;
        end else begin
            res.v = v;
            res.q = q;
        end
        return res;
    endfunction

    assign o_op_j = resolve(i_reg_src.qj, i_reg_src.vj, i_rob);
    assign o_op_k = resolve(i_reg_src.qk, i_reg_src.vk, i_rob);

    // A tag that survives must be the register file's own and still pending in the ROB
    always_comb begin
        assert final ((o_op_j.q == '0 || o_op_j.q == i_reg_src.qj) &&
                      (o_op_j.q == '0 || !i_rob.ready[o_op_j.q]))
            else $error("operand j kept a tag that is not pending");
        assert final ((o_op_k.q == '0 || o_op_k.q == i_reg_src.qk) &&
                      (o_op_k.q == '0 || !i_rob.ready[o_op_k.q]))
            else $error("operand k kept a tag that is not pending");
    end

endmodule

`default_nettype wire

/* tb/tb_issue_stage.sv */
// Directed testbench for the issue stage, with register-file and ROB models.
// Each test presents one instruction, checks the strobes, then the registered pulses.
`timescale 1ns/1ps
`default_nettype none

module tb_issue_stage;
    import issue_pkg::*;

    localparam int MAX_CYCLES = 2000;  // 38 tests of 2 to 4 cycles each, wide margin

    logic          clk;
    logic          rst;
    logic          valid;
    fetch_pkt_t    fetch;
    logic          shift;
    reg_idx_t      rs1;
    reg_idx_t      rs2;
    reg_src_t      reg_src;
    logic          load_tag;
    tag_t          tag;
    reg_idx_t      rd;
    rob_status_t   rob;
    logic          rob_valid;
    rob_entry_t    rob_ent;
    logic          alu_ready;
    logic          alu_valid;
    alu_rs_entry_t alu_ent;
    logic          cmp_ready;
    logic          cmp_valid;
    cmp_rs_entry_t cmp_ent;

    word_t                rf_val [32];
    tag_t                 rf_tag [32];
    logic [ROB_DEPTH-1:0] rob_ready;
    word_t                rob_vals [ROB_DEPTH];
    tag_t                 free_tag;
    int                   errors;
    int                   tests;
    int                   cycles;

    issue_stage issue_stage_i (
        .clk         (clk),
        .rst         (rst),
        .i_valid     (valid),
        .i_fetch     (fetch),
        .o_shift     (shift),
        .o_rs1       (rs1),
        .o_rs2       (rs2),
        .i_reg_src   (reg_src),
        .o_load_tag  (load_tag),
        .o_tag       (tag),
        .o_rd        (rd),
        .i_rob       (rob),
        .o_rob_valid (rob_valid),
        .o_rob       (rob_ent),
        .i_alu_ready (alu_ready),
        .o_alu_valid (alu_valid),
        .o_alu       (alu_ent),
        .i_cmp_ready (cmp_ready),
        .o_cmp_valid (cmp_valid),
        .o_cmp       (cmp_ent)
    );

    // Register file read answers in the same cycle
    always_comb begin
        reg_src.vj = rf_val[rs1];
        reg_src.qj = rf_tag[rs1];
        reg_src.vk = rf_val[rs2];
        reg_src.qk = rf_tag[rs2];
    end

    always_comb begin
        rob.ready    = rob_ready;
        rob.free_tag = free_tag;
        for (int i = 0; i < ROB_DEPTH; i++) begin
            rob.vals[i] = rob_vals[i];
        end
    end

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout: the tests did not finish within %0d cycles", MAX_CYCLES);
            $display("Done: errors found");
            $finish;
        end
    end

    function automatic word_t r_type(input logic [6:0] f7, input reg_idx_t s2, input reg_idx_t s1,
                                     input logic [2:0] f3, input reg_idx_t d, input logic [6:0] opc);
        return {f7, s2, s1, f3, d, opc};
    endfunction

    function automatic word_t i_type(input logic [11:0] imm, input reg_idx_t s1,
                                     input logic [2:0] f3, input reg_idx_t d, input logic [6:0] opc);
        return {imm, s1, f3, d, opc};
    endfunction

    function automatic word_t b_type(input logic [12:0] off, input reg_idx_t s2, input reg_idx_t s1,
                                     input logic [2:0] f3);
        return {off[12], off[10:5], s2, s1, f3, off[4:1], off[11], 7'b1100011};
    endfunction

    function automatic word_t u_type(input logic [19:0] imm, input reg_idx_t d, input logic [6:0] opc);
        return {imm, d, opc};
    endfunction

    task automatic check(input string name, input string field, input logic [63:0] exp,
                         input logic [63:0] act);
        if (exp !== act) begin
            $display("ERR %s %s: expected %0h, actual %0h", name, field, exp, act);
            errors++;
        end
    endtask

    // Called on a falling edge, gives each test its own ROB tag
    task automatic start_case(output int start);
        start    = errors;
        free_tag = tag_t'(tests % 7 + 1);
    endtask

    task automatic report_case(input string name, input int start);
        tests++;
        if (errors == start) begin
            $display("ok   %s", name);
        end else begin
            $display("FAIL %s with %0d mismatches", name, errors - start);
        end
    endtask

    task automatic present(input word_t inst, input word_t pc, input logic pred);
        @(negedge clk);
        fetch = '{pc: pc, inst: inst, br_pred: pred};
        valid = 1'b1;
        #5;  // Strobes settle long before the rising edge
    endtask

    task automatic expect_quiet(input string name);
        check(name, "o_shift", 0, shift);
        check(name, "o_load_tag", 0, load_tag);
        @(negedge clk);
        check(name, "o_alu_valid", 0, alu_valid);
        check(name, "o_cmp_valid", 0, cmp_valid);
        check(name, "o_rob_valid", 0, rob_valid);
    endtask

    task automatic expect_alu(input string name, input alu_op_t op, input word_t vj, input tag_t qj,
                              input word_t vk, input tag_t qk, input reg_idx_t rd_exp);
        check(name, "o_shift", 1, shift);
        check(name, "o_load_tag", 1, load_tag);
        check(name, "o_tag", free_tag, tag);
        check(name, "o_rd", rd_exp, rd);
        @(negedge clk);
        valid = 1'b0;
        check(name, "o_alu_valid", 1, alu_valid);
        check(name, "o_cmp_valid", 0, cmp_valid);
        check(name, "o_rob_valid", 1, rob_valid);
        check(name, "alu_op", op, alu_ent.alu_op);
        check(name, "vj", vj, alu_ent.vj);
        check(name, "qj", qj, alu_ent.qj);
        check(name, "vk", vk, alu_ent.vk);
        check(name, "qk", qk, alu_ent.qk);
        check(name, "dest", free_tag, alu_ent.dest);
        check(name, "rob op", REG, rob_ent.op);
        check(name, "rob dest", rd_exp, rob_ent.dest);
    endtask

    task automatic expect_cmp(input string name, input cmp_op_t op, input logic is_br,
                              input word_t vj, input word_t vk, input reg_idx_t rd_exp,
                              input word_t b_imm);
        check(name, "o_shift", 1, shift);
        check(name, "o_load_tag", !is_br, load_tag);
        if (!is_br) begin
            check(name, "o_tag", free_tag, tag);
            check(name, "o_rd", rd_exp, rd);
        end
        @(negedge clk);
        valid = 1'b0;
        check(name, "o_alu_valid", 0, alu_valid);
        check(name, "o_cmp_valid", 1, cmp_valid);
        check(name, "o_rob_valid", 1, rob_valid);
        check(name, "cmp_op", op, cmp_ent.cmp_op);
        check(name, "is_br", is_br, cmp_ent.is_br);
        check(name, "vj", vj, cmp_ent.vj);
        check(name, "qj", 0, cmp_ent.qj);
        check(name, "vk", vk, cmp_ent.vk);
        check(name, "qk", 0, cmp_ent.qk);
        check(name, "dest", free_tag, cmp_ent.dest);
        check(name, "rob op", is_br ? BR : REG, rob_ent.op);
        check(name, "rob dest", is_br ? 5'd0 : rd_exp, rob_ent.dest);
        if (is_br) begin
            check(name, "pc", fetch.pc, cmp_ent.pc);
            check(name, "b_imm", b_imm, cmp_ent.b_imm);
            check(name, "br_pred", fetch.br_pred, cmp_ent.br_pred);
        end
    endtask

    task automatic reset_idle;
        int start;
        start_case(start);
        expect_quiet("reset_idle");
        report_case("reset_idle", start);
    endtask

    task automatic alu_reg_op(input string name, input logic [6:0] f7, input logic [2:0] f3,
                              input alu_op_t op);
        int       start;
        reg_idx_t rd_n;
        start_case(start);
        rd_n = reg_idx_t'(f3 + 5'd10);
        present(r_type(f7, 5'd2, 5'd1, f3, rd_n, op_reg), 32'h100, 1'b0);
        expect_alu(name, op, rf_val[1], 0, rf_val[2], 0, rd_n);
        report_case(name, start);
    endtask

    task automatic alu_imm_op(input string name, input logic [11:0] imm, input logic [2:0] f3,
                              input alu_op_t op);
        int       start;
        reg_idx_t rd_n;
        start_case(start);
        rd_n = reg_idx_t'(f3 + 5'd20);
        present(i_type(imm, 5'd3, f3, rd_n, op_imm), 32'h104, 1'b0);
        expect_alu(name, op, rf_val[3], 0, {{20{imm[11]}}, imm}, 0, rd_n);  // I immediate
        report_case(name, start);
    endtask

    // x1 waits on a finished ROB entry, x2 on one still in flight
    task automatic forward_sources;
        int start;
        start_case(start);
        rf_tag[1]    = 3'd3;
        rob_ready[3] = 1'b1;
        rf_tag[2]    = 3'd5;
        rob_ready[5] = 1'b0;
        present(r_type(7'h00, 5'd2, 5'd1, 3'b000, 5'd4, op_reg), 32'h108, 1'b0);
        expect_alu("forward", alu_add, rob_vals[3], 0, rf_val[2], 3'd5, 5'd4);
        rf_tag[1] = '0;
        rf_tag[2] = '0;
        rob_ready = '0;
        report_case("forward", start);
    endtask

    task automatic set_less_than(input string name, input logic is_imm, input logic [2:0] f3,
                                 input cmp_op_t op);
        int    start;
        word_t inst;
        word_t vk;
        start_case(start);
        if (is_imm) begin
            inst = i_type(12'hff9, 5'd5, f3, 5'd8, op_imm);
            vk   = 32'hffff_fff9;
        end else begin
            inst = r_type(7'h00, 5'd6, 5'd5, f3, 5'd8, op_reg);
            vk   = rf_val[6];
        end
        present(inst, 32'h200, 1'b0);
        expect_cmp(name, op, 1'b0, rf_val[5], vk, 5'd8, '0);
        report_case(name, start);
    endtask

    task automatic branch_op(input string name, input logic [2:0] f3, input cmp_op_t op,
                             input logic [12:0] off, input logic pred);
        int start;
        start_case(start);
        present(b_type(off, 5'd12, 5'd11, f3), $urandom & 32'hffff_fffc, pred);
        expect_cmp(name, op, 1'b1, rf_val[11], rf_val[12], 5'd0, {{19{off[12]}}, off});
        report_case(name, start);
    endtask

    task automatic upper_imm(input string name, input logic [6:0] opc, input logic [19:0] imm);
        int    start;
        word_t pc;
        start_case(start);
        pc = $urandom & 32'hffff_fffc;
        present(u_type(imm, 5'd13, opc), pc, 1'b0);
        expect_alu(name, alu_add, (opc == op_auipc) ? pc : 32'h0, 0, {imm, 12'h000}, 0, 5'd13);
        report_case(name, start);
    endtask

    // Cause 0 stalls the ALU station, 1 fills the ROB, 2 stalls the compare station
    task automatic stall_then_issue(input string name, input int cause);
        int   start;
        tag_t saved;
        start_case(start);
        saved     = free_tag;
        alu_ready = (cause != 0);
        free_tag  = (cause == 1) ? tag_t'(0) : saved;
        cmp_ready = (cause != 2);
        present(r_type(7'h00, 5'd2, 5'd1, (cause == 2) ? 3'b010 : 3'b000, 5'd14, op_reg),
                32'h300, 1'b0);
        expect_quiet(name);
        alu_ready = 1'b1;  // Queue still holds the same instruction
        cmp_ready = 1'b1;
        free_tag  = saved;
        #5;
        if (cause == 2) begin
            expect_cmp(name, cmp_blt, 1'b0, rf_val[1], rf_val[2], 5'd14, '0);
        end else begin
            expect_alu(name, alu_add, rf_val[1], 0, rf_val[2], 0, 5'd14);
        end
        report_case(name, start);
    endtask

    task automatic refused_inst(input string name, input word_t inst);
        int start;
        start_case(start);
        present(inst, 32'h400, 1'b0);
        expect_quiet(name);
        valid = 1'b0;
        report_case(name, start);
    endtask

    initial begin
        void'($urandom(32'h5767));
        rst       = 1'b1;
        valid     = 1'b0;
        fetch     = '0;
        alu_ready = 1'b1;
        cmp_ready = 1'b1;
        free_tag  = 3'd1;
        rob_ready = '0;
        errors    = 0;
        tests     = 0;
        cycles    = 0;
        for (int i = 0; i < 32; i++) begin
            rf_val[i] = (i == 0) ? '0 : $urandom;
            rf_tag[i] = '0;
        end
        for (int i = 0; i < ROB_DEPTH; i++) begin
            rob_vals[i] = $urandom;
        end
        repeat (5) @(negedge clk);
        rst = 1'b0;

        reset_idle();
        alu_reg_op("add", 7'h00, 3'b000, alu_add);
        alu_reg_op("sub", 7'h20, 3'b000, alu_sub);
        alu_reg_op("sll", 7'h00, 3'b001, alu_sll);
        alu_reg_op("xor", 7'h00, 3'b100, alu_xor);
        alu_reg_op("srl", 7'h00, 3'b101, alu_srl);
        alu_reg_op("sra", 7'h20, 3'b101, alu_sra);
        alu_reg_op("or", 7'h00, 3'b110, alu_or);
        alu_reg_op("and", 7'h00, 3'b111, alu_and);
        alu_imm_op("addi", 12'hed4, 3'b000, alu_add);
        alu_imm_op("addi_bit30", 12'h4d2, 3'b000, alu_add);  // Bit 30 set is still an add
        alu_imm_op("xori", 12'h0f0, 3'b100, alu_xor);
        alu_imm_op("ori", 12'h801, 3'b110, alu_or);
        alu_imm_op("andi", 12'h7ff, 3'b111, alu_and);
        alu_imm_op("slli", 12'h007, 3'b001, alu_sll);
        alu_imm_op("srli", 12'h01f, 3'b101, alu_srl);
        alu_imm_op("srai", 12'h409, 3'b101, alu_sra);
        forward_sources();
        set_less_than("slt", 1'b0, 3'b010, cmp_blt);
        set_less_than("sltu", 1'b0, 3'b011, cmp_bltu);
        set_less_than("slti", 1'b1, 3'b010, cmp_blt);
        set_less_than("sltiu", 1'b1, 3'b011, cmp_bltu);
        branch_op("beq", 3'b000, cmp_beq, 13'h0010, 1'b1);
        branch_op("bne", 3'b001, cmp_bne, 13'h1ff0, 1'b0);
        branch_op("blt", 3'b100, cmp_blt, 13'h0ffe, 1'b1);
        branch_op("bge", 3'b101, cmp_bge, 13'h1002, 1'b0);
        branch_op("bltu", 3'b110, cmp_bltu, 13'h0040, 1'b1);
        branch_op("bgeu", 3'b111, cmp_bgeu, 13'h1800, 1'b0);
        upper_imm("lui", op_lui, 20'hbeef5);
        upper_imm("auipc", op_auipc, 20'h12345);
        stall_then_issue("alu_busy", 0);
        stall_then_issue("rob_full", 1);
        stall_then_issue("cmp_busy", 2);
        refused_inst("rd_zero", i_type(12'h005, 5'd1, 3'b000, 5'd0, op_imm));
        refused_inst("load", i_type(12'h010, 5'd1, 3'b010, 5'd7, op_load));
        refused_inst("store", r_type(7'h00, 5'd2, 5'd1, 3'b010, 5'd4, op_store));
        refused_inst("jal", u_type(20'h00010, 5'd1, op_jal));
        refused_inst("jalr", i_type(12'h000, 5'd1, 3'b000, 5'd1, op_jalr));

        $display("%0d tests run, %0d errors", tests, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire
